/* src.f */
nodePkg.sv
ctrlPkg.sv
respFifo.sv
respMerge.sv
tickGen.sv
intSequencer.sv
nodeTop.sv
tbNode.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top tbNode -o simNode
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

output=$(./obj_dir/simNode 2>&1)
simStatus=$?
echo "$output"

if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

/* tbNode.sv */
`timescale 1ns/1ps

module tbNode import nodePkg::*, ctrlPkg::*;
();

	logic EXTCLK;
	logic reset;
	logic streamWrite;
	respWord streamWord;
	logic streamFull;
	logic netWrite;
	respWord netWord;
	logic netFull;
	logic localValid;
	respWord localWord;
	logic localRead;
	logic coreValid;
	respWord coreWord;
	logic tick;
	logic intReq;
	logic intEnable;
	logic intAck;
	logic coreEmpty;
	logic msgBreak;
	logic coreStop;
	logic msgReq;

	// words still owed to the core in arrival order
	respWord expQ[$];
	int localReadCount;

	nodeTop uut (.*);

	initial
	begin
		EXTCLK = 1'b0;
		forever #20 EXTCLK = ~EXTCLK;
	end

	// ========================================
	// checking
	// ========================================

	task automatic abortRun(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1, "run aborted");
	endtask

	task automatic checkValue(input logic [127:0] actual, input logic [127:0] expected,
		input string msg);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t: %s (got %0h, expected %0h)",
				$time, msg, actual, expected);
			$display("Simulation failed");
			$fatal(1, "mismatch");
		end
	endtask

	// scoreboard sampling the core channel mid-cycle
	always @(negedge EXTCLK)
	begin
		if (!reset)
		begin
			if (localRead)
				localReadCount++;
			if (coreValid)
			begin
				if (expQ.size() == 0)
					abortRun("core received a word that was never sent");
				else
					checkValue(128'(coreWord), 128'(expQ.pop_front()), "core word order");
			end
		end
	end

	function automatic respWord randomWord();
		respWord w;
		w.size = 3'($urandom());
		w.tag = 8'($urandom());
		w.data = {$urandom(), $urandom()};
		return w;
	endfunction

	// ========================================
	// waits on DUT events
	// ========================================

	task automatic waitDrained();
		int n;
		n = 0;
		while (expQ.size() != 0)
		begin
			@(negedge EXTCLK);
			n++;
			if (n > 200)
				abortRun("expected words never reached the core");
		end
		@(negedge EXTCLK);
	endtask

	task automatic waitLocalRead();
		int n;
		n = 0;
		do
		begin
			@(negedge EXTCLK);
			n++;
			if (n > 100)
				abortRun("local word was never read");
		end
		while (!localRead);
	endtask

	task automatic waitTick();
		int n;
		n = 0;
		do
		begin
			@(negedge EXTCLK);
			n++;
			if (n > 3 * TickScale)
				abortRun("no tick pulse seen");
		end
		while (!tick);
	endtask

	task automatic waitMsgReq();
		int n;
		n = 0;
		do
		begin
			@(negedge EXTCLK);
			n++;
			if (n > 50)
				abortRun("message request never issued");
		end
		while (!msgReq);
	endtask

	task automatic countMsgReq(input int cycles, output int n);
		n = 0;
		repeat (cycles)
		begin
			@(negedge EXTCLK);
			if (msgReq)
				n++;
		end
	endtask

	// ========================================
	// directed tests
	// ========================================

	task automatic testLocalWord();
		respWord w;
		w = randomWord();
		localReadCount = 0;
		expQ.push_back(w);
		@(posedge EXTCLK);
		localValid <= 1'b1;
		localWord <= w;
		waitLocalRead();
		// source runs dry after one word
		@(posedge EXTCLK);
		localValid <= 1'b0;
		waitDrained();
		checkValue(128'(localReadCount), 128'(1), "localRead pulse count");
	endtask

	task automatic testStreamOrder();
		respWord w;
		for (int i = 0; i < FifoDepth; i++)
		begin
			w = randomWord();
			expQ.push_back(w);
			@(posedge EXTCLK);
			streamWrite <= 1'b1;
			streamWord <= w;
			@(negedge EXTCLK);
			checkValue(128'(streamFull), 128'(0), "streamFull during burst");
		end
		@(posedge EXTCLK);
		streamWrite <= 1'b0;
		waitDrained();
	endtask

	task automatic testPriority();
		respWord nw[6];
		respWord sw[6];
		respWord lw;
		localReadCount = 0;
		lw = randomWord();
		foreach (nw[i])
		begin
			nw[i] = randomWord();
			sw[i] = randomWord();
		end
		// network drains first, then stream, then local
		foreach (nw[i])
			expQ.push_back(nw[i]);
		foreach (sw[i])
			expQ.push_back(sw[i]);
		expQ.push_back(lw);
		foreach (nw[i])
		begin
			@(posedge EXTCLK);
			netWrite <= 1'b1;
			netWord <= nw[i];
			streamWrite <= 1'b1;
			streamWord <= sw[i];
			// local word shows up once the network FIFO holds data
			if (i == 1)
			begin
				localValid <= 1'b1;
				localWord <= lw;
			end
			@(negedge EXTCLK);
			checkValue(128'(netFull), 128'(0), "netFull during burst");
		end
		@(posedge EXTCLK);
		netWrite <= 1'b0;
		streamWrite <= 1'b0;
		waitLocalRead();
		@(posedge EXTCLK);
		localValid <= 1'b0;
		waitDrained();
		checkValue(128'(localReadCount), 128'(1), "localRead pulses under priority");
	endtask

	task automatic testTick();
		int gap;
		waitTick();
		repeat (4)
		begin
			gap = 0;
			do
			begin
				@(negedge EXTCLK);
				gap++;
				if (gap == 1)
					checkValue(128'(tick), 128'(0), "tick pulse width");
				if (gap > 2 * TickScale)
					abortRun("tick pulse missing");
			end
			while (!tick);
			checkValue(128'(gap), 128'(TickScale), "tick period");
		end
	endtask

	task automatic raiseInterrupt();
		@(posedge EXTCLK);
		intReq <= 1'b1;
		@(posedge EXTCLK);
		intReq <= 1'b0;
		@(negedge EXTCLK);
	endtask

	task automatic ackInterrupt();
		checkValue(128'(coreStop), 128'(1), "coreStop before intAck");
		@(posedge EXTCLK);
		intAck <= 1'b1;
		@(posedge EXTCLK);
		intAck <= 1'b0;
		@(negedge EXTCLK);
		checkValue(128'(coreStop), 128'(0), "coreStop after intAck");
	endtask

	task automatic testIntEnabled();
		int n;
		@(posedge EXTCLK);
		intEnable <= 1'b1;
		coreEmpty <= 1'b0;
		msgBreak <= 1'b0;
		raiseInterrupt();
		checkValue(128'(coreStop), 128'(1), "coreStop after intReq");
		countMsgReq(8, n);
		checkValue(128'(n), 128'(0), "msgReq while core busy");
		@(posedge EXTCLK);
		coreEmpty <= 1'b1;
		waitMsgReq();
		countMsgReq(8, n);
		checkValue(128'(n), 128'(0), "msgReq after the single pulse");
		ackInterrupt();
		@(posedge EXTCLK);
		coreEmpty <= 1'b0;
	endtask

	task automatic testIntOther();
		int n;
		@(posedge EXTCLK);
		intEnable <= 1'b0;
		raiseInterrupt();
		repeat (4)
		begin
			@(negedge EXTCLK);
			checkValue(128'(coreStop), 128'(0), "coreStop with interrupts disabled");
		end
		// core parked on a message breakpoint
		@(posedge EXTCLK);
		intEnable <= 1'b1;
		coreEmpty <= 1'b1;
		msgBreak <= 1'b1;
		raiseInterrupt();
		checkValue(128'(coreStop), 128'(1), "coreStop with msgBreak");
		countMsgReq(8, n);
		checkValue(128'(n), 128'(0), "msgReq during msgBreak");
		@(posedge EXTCLK);
		msgBreak <= 1'b0;
		waitMsgReq();
		countMsgReq(8, n);
		checkValue(128'(n), 128'(0), "msgReq after msgBreak release");
		ackInterrupt();
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial
	begin
		void'($urandom(95104));
		reset = 1'b1;
		streamWrite = 1'b0;
		streamWord = '0;
		netWrite = 1'b0;
		netWord = '0;
		localValid = 1'b0;
		localWord = '0;
		intReq = 1'b0;
		intEnable = 1'b0;
		intAck = 1'b0;
		coreEmpty = 1'b0;
		msgBreak = 1'b0;
		localReadCount = 0;
		repeat (4) @(posedge EXTCLK);
		reset <= 1'b0;
		testLocalWord();
		testStreamOrder();
		testPriority();
		testTick();
		testIntEnabled();
		testIntOther();
		$display("Simulation passed");
		$finish;
	end

endmodule

/* nodeTop.sv */
`timescale 1ns/1ps

module nodeTop import nodePkg::*;
(
	input logic EXTCLK,
	input logic reset,
	// stream controller write port
	input logic streamWrite,
	input respWord streamWord,
	output logic streamFull,
	// network controller write port
	input logic netWrite,
	input respWord netWord,
	output logic netFull,
	// local memory return
	input logic localValid,
	input respWord localWord,
	output logic localRead,
	// core data channel
	output logic coreValid,
	output respWord coreWord,
	// time tick for the stream controller
	output logic tick,
	// external interrupt
	input logic intReq,
	input logic intEnable,
	input logic intAck,
	input logic coreEmpty,
	input logic msgBreak,
	output logic coreStop,
	output logic msgReq
);

	logic netEmpty;
	logic netPop;
	respWord netHead;
	logic streamEmpty;
	logic streamPop;
	respWord streamHead;

	// ========================================
	// response datapath
	// ========================================

	respFifo netFifo
	(
		.EXTCLK(EXTCLK),
		.reset(reset),
		.write(netWrite),
		.writeWord(netWord),
		.pop(netPop),
		.headWord(netHead),
		.empty(netEmpty),
		.full(netFull)
	);

	respFifo streamFifo
	(
		.EXTCLK(EXTCLK),
		.reset(reset),
		.write(streamWrite),
		.writeWord(streamWord),
		.pop(streamPop),
		.headWord(streamHead),
		.empty(streamEmpty),
		.full(streamFull)
	);

	respMerge merge
	(
		.EXTCLK(EXTCLK),
		.reset(reset),
		.netEmpty(netEmpty),
		.netHead(netHead),
		.netPop(netPop),
		.streamEmpty(streamEmpty),
		.streamHead(streamHead),
		.streamPop(streamPop),
		.localValid(localValid),
		.localWord(localWord),
		.localRead(localRead),
		.coreValid(coreValid),
		.coreWord(coreWord)
	);

	// ========================================
	// control
	// ========================================

	tickGen ticker
	(
		.EXTCLK(EXTCLK),
		.reset(reset),
		.tick(tick)
	);

	intSequencer intSeq
	(
		.EXTCLK(EXTCLK),
		.reset(reset),
		.intReq(intReq),
		.intEnable(intEnable),
		.intAck(intAck),
		.coreEmpty(coreEmpty),
		.msgBreak(msgBreak),
		.coreStop(coreStop),
		.msgReq(msgReq)
	);

endmodule

/* intSequencer.sv */
`timescale 1ns/1ps

module intSequencer import ctrlPkg::*;
(
	input logic EXTCLK,
	input logic reset,
	input logic intReq,
	input logic intEnable,
	input logic intAck,
	input logic coreEmpty,
	input logic msgBreak,
	output logic coreStop,
	output logic msgReq
);

	intState state;
	intState nextState;
	logic drained;

	// core idle and not parked on a message breakpoint
	assign drained = coreEmpty & ~msgBreak;

	always_comb
	begin
		nextState = state;
		case (state)
			intIdle:
				if (intReq)
					nextState = intPending;
			intPending:
				if (intAck)
					nextState = intIdle;
				else if (drained)
					nextState = intRequested;
			intRequested:
				if (intAck)
					nextState = intIdle;
			default:
				nextState = intIdle;
		endcase
		// disabled interrupts drop everything
		if (!intEnable)
			nextState = intIdle;
	end

	always_ff @(posedge EXTCLK)
	begin
		if (reset)
		begin
			state <= intIdle;
			msgReq <= 1'b0;
		end
		else
		begin
			state <= nextState;
			// single pulse on entry to intRequested
			msgReq <= (state == intPending) && (nextState == intRequested);
		end
	end

	// hold the core while the interrupt is outstanding
	assign coreStop = (state != intIdle);

endmodule

/* tickGen.sv */
`timescale 1ns/1ps

module tickGen import ctrlPkg::*;
(
	input logic EXTCLK,
	input logic reset,
	output logic tick
);

	logic [$clog2(TickScale)-1:0] tickCnt;
	logic lastCount;

	// final count of the interval
	assign lastCount = (int'(tickCnt) == TickScale - 1);

	// interval counter for the stream controller
	always_ff @(posedge EXTCLK)
	begin
		if (reset)
		begin
			tickCnt <= '0;
			tick <= 1'b0;
		end
		else
		begin
			// restart together with the tick
			if (lastCount)
				tickCnt <= '0;
			else
				tickCnt <= tickCnt + 1'b1;
			tick <= lastCount;
		end
	end

endmodule

/* respMerge.sv */
`timescale 1ns/1ps

module respMerge import nodePkg::*;
(
	input logic EXTCLK,
	input logic reset,
	// network source, highest priority
	input logic netEmpty,
	input respWord netHead,
	output logic netPop,
	// stream source
	input logic streamEmpty,
	input respWord streamHead,
	output logic streamPop,
	// local memory source, lowest priority
	input logic localValid,
	input respWord localWord,
	output logic localRead,
	// core data channel
	output logic coreValid,
	output respWord coreWord
);

	logic takeNet;
	logic takeStream;
	logic takeLocal;
	logic takeAny;
	respWord selWord;

	// fixed priority select
	always_comb
	begin
		takeNet = ~netEmpty;
		takeStream = netEmpty & ~streamEmpty;
		takeLocal = netEmpty & streamEmpty & localValid;
		takeAny = takeNet | takeStream | takeLocal;
	end

	// pop the chosen source in the same cycle
	assign netPop = takeNet;
	assign streamPop = takeStream;
	assign localRead = takeLocal;

	always_comb
	begin
		if (takeNet)
			selWord = netHead;
		else if (takeStream)
			selWord = streamHead;
		else
			selWord = localWord;
	end

	// one register stage towards the core without stall
	always_ff @(posedge EXTCLK)
	begin
		if (reset)
			coreValid <= 1'b0;
		else
			coreValid <= takeAny;
	end

	always_ff @(posedge EXTCLK)
	begin
		if (takeAny)
			coreWord <= selWord;
	end

endmodule

/* respFifo.sv */
`timescale 1ns/1ps

module respFifo import nodePkg::*;
(
	input logic EXTCLK,
	input logic reset,
	input logic write,
	input respWord writeWord,
	input logic pop,
	output respWord headWord,
	output logic empty,
	output logic full
);

	respWord mem [FifoDepth];
	logic [FifoAddrWidth-1:0] wrPtr;
	logic [FifoAddrWidth-1:0] rdPtr;
	logic [FifoAddrWidth:0] count;
	logic doWrite;
	logic doPop;

	// writes while full and pops while empty are dropped
	assign doWrite = write & ~full;
	assign doPop = pop & ~empty;

	// show-ahead output of the oldest entry
	assign headWord = mem[rdPtr];
	assign empty = (count == '0);
	assign full = (count == (FifoAddrWidth + 1)'(FifoDepth));

	// storage array
	always_ff @(posedge EXTCLK)
	begin
		if (doWrite)
			mem[wrPtr] <= writeWord;
	end

	// pointers wrap naturally since depth is a power of two
	always_ff @(posedge EXTCLK)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doWrite, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* ctrlPkg.sv */
package ctrlPkg;

// ========================================
// time tick
// ========================================

// clock cycles between stream controller ticks
localparam int TickScale = 20;

// ========================================
// external interrupt sequencer
// ========================================

// idle, core being stopped, message request issued
typedef enum logic [1:0]
{
	intIdle,
	intPending,
	intRequested
} intState;

endpackage

/* nodePkg.sv */
package nodePkg;

// ========================================
// response word geometry
// ========================================

// returned data word
localparam int DataWidth = 64;

// transaction tag from the requester
localparam int TagWidth = 8;

// size code of the returned word
localparam int SizeWidth = 3;

// ========================================
// response FIFO geometry
// ========================================

localparam int FifoDepth = 16;
localparam int FifoAddrWidth = 4;

// size sits in the top bits and data in the bottom bits
typedef struct packed
{
	logic [SizeWidth-1:0] size;
	logic [TagWidth-1:0] tag;
	logic [DataWidth-1:0] data;
} respWord;

endpackage
